/* design/iob_wb_pkg.sv */
package iob_wb_pkg;

   // Direction of one Wishbone cycle.
   typedef enum logic {
      WB_READ  = 1'b0, // All strobe bits low.
      WB_WRITE = 1'b1  // At least one strobe bit high.
   } wb_op_e;

   // Slave addressed by the current cycle.
   typedef enum logic {
      SLV_RAM  = 1'b0,
      SLV_REGS = 1'b1
   } wb_slave_e;

   localparam int REGS_BASE_BIT = 12; // Set means register block, clear means RAM.

endpackage

/* design/periph_pkg.sv */
package periph_pkg;

   // Word index inside the register block.
   typedef enum logic [1:0] {
      REG_ID      = 2'd0, // Read-only identifier.
      REG_SCRATCH = 2'd1, // Byte-writable scratch word.
      REG_WCOUNT  = 2'd2  // Count of write acks.
   } reg_map_e;

   localparam logic [31:0] PERIPH_ID = 32'h1b2c_0a01;

   typedef enum logic [1:0] {
      RAM_IDLE = 2'd0,
      RAM_WAIT = 2'd1, // Wait states in progress.
      RAM_ACK  = 2'd2  // Access and acknowledge.
   } ram_state_e;

endpackage

/* design/iob_iob2wishbone.sv */
`timescale 1ns/1ps

module iob_iob2wishbone
   import iob_wb_pkg::*;
#(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int READ_BYTES = 4
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                iob_avalid_i,
   input  logic [  ADDR_W-1:0] iob_addr_i,
   input  logic [  DATA_W-1:0] iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_rvalid_o,
   output logic [  DATA_W-1:0] iob_rdata_o,
   output logic                iob_ready_o,
   output logic [  ADDR_W-1:0] wb_addr_o,
   output logic [DATA_W/8-1:0] wb_select_o,
   output logic                wb_we_o,
   output logic                wb_cyc_o,
   output logic                wb_stb_o,
   output logic [  DATA_W-1:0] wb_data_o,
   input  logic                wb_ack_i,
   input  logic [  DATA_W-1:0] wb_data_i
);

   localparam int STRB_W = DATA_W / 8;
   localparam logic [STRB_W-1:0] RB_MASK = STRB_W'((1 << READ_BYTES) - 1);

   wb_op_e              op;
   logic                accept;
   logic                we;
   logic [STRB_W-1:0]   select;

   logic                avalid_r;
   logic [ADDR_W-1:0]   addr_r;
   logic [DATA_W-1:0]   wdata_r;
   logic [STRB_W-1:0]   select_r;
   logic                we_r;
   logic [DATA_W-1:0]   rdata_r;
   logic                ack_r;

   assign op     = (|iob_wstrb_i) ? WB_WRITE : WB_READ;
   assign we     = (op == WB_WRITE);
   assign select = we ? iob_wstrb_i : RB_MASK << iob_addr_i[1:0]; // Read lanes follow the address.
   assign accept = iob_avalid_i & iob_ready_o;

   // First cycle comes straight from the request, later ones from the copy.
   assign wb_stb_o    = accept | avalid_r;
   assign wb_cyc_o    = wb_stb_o;
   assign wb_addr_o   = accept ? iob_addr_i : addr_r;
   assign wb_data_o   = accept ? iob_wdata_i : wdata_r;
   assign wb_select_o = accept ? select : select_r;
   assign wb_we_o     = accept ? we : we_r;

   assign iob_ready_o  = ~avalid_r | ack_r;
   assign iob_rvalid_o = ack_r & ~we_r; // Writes complete without a read pulse.
   assign iob_rdata_o  = rdata_r;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         avalid_r <= 1'b0;
         ack_r    <= 1'b0;
      end else begin
         ack_r <= wb_ack_i;
         if (wb_ack_i) begin
            avalid_r <= 1'b0; // Cycle done.
         end else if (accept) begin
            avalid_r <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         addr_r   <= iob_addr_i;
         wdata_r  <= iob_wdata_i;
         select_r <= select;
         we_r     <= we;
      end
      rdata_r <= wb_data_i;
   end

endmodule

/* design/wb_decoder.sv */
`timescale 1ns/1ps

module wb_decoder
   import iob_wb_pkg::*;
#(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  logic              wb_cyc_i,
   input  logic              wb_stb_i,
   input  logic [ADDR_W-1:0] wb_addr_i,
   input  logic              ram_ack_i,
   input  logic [DATA_W-1:0] ram_data_i,
   input  logic              regs_ack_i,
   input  logic [DATA_W-1:0] regs_data_i,
   output logic              ram_stb_o,
   output logic              regs_stb_o,
   output logic              wb_ack_o,
   output logic [DATA_W-1:0] wb_data_o
);

   wb_slave_e slave_d;
   wb_slave_e slave_q;
   logic      active;

   assign slave_d = wb_addr_i[REGS_BASE_BIT] ? SLV_REGS : SLV_RAM;

   // Target is held for the whole cycle.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         active  <= 1'b0;
         slave_q <= SLV_RAM;
      end else if (wb_ack_o) begin
         active <= 1'b0;
      end else if (wb_cyc_i && wb_stb_i && !active) begin
         active  <= 1'b1;
         slave_q <= slave_d;
      end
   end

   assign ram_stb_o  = active & (slave_q == SLV_RAM);
   assign regs_stb_o = active & (slave_q == SLV_REGS);
   assign wb_ack_o   = active & ((slave_q == SLV_REGS) ? regs_ack_i : ram_ack_i);
   assign wb_data_o  = (slave_q == SLV_REGS) ? regs_data_i : ram_data_i;

endmodule

/* design/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram
   import iob_wb_pkg::*;
   import periph_pkg::*;
#(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int RAM_ADDR_W = 8,
   parameter int RAM_WAIT   = 2
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                stb_i,
   input  logic                we_i,
   input  logic [  ADDR_W-1:0] addr_i,
   input  logic [DATA_W/8-1:0] sel_i,
   input  logic [  DATA_W-1:0] data_i,
   output logic                ack_o,
   output logic [  DATA_W-1:0] data_o
);

   localparam int CNT_W = (RAM_WAIT > 1) ? $clog2(RAM_WAIT) : 1;
   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'((RAM_WAIT > 0) ? RAM_WAIT - 1 : 0);

   logic [DATA_W-1:0]     mem [2**RAM_ADDR_W];
   ram_state_e            state;
   logic [CNT_W-1:0]      wait_cnt;
   logic [RAM_ADDR_W-1:0] word_idx;
   wb_op_e                op;
   logic                  wr_en;

   assign word_idx = addr_i[RAM_ADDR_W+1:2];
   assign op       = wb_op_e'(we_i);
   assign ack_o    = (state == RAM_ACK);
   assign wr_en    = ack_o & stb_i & (op == WB_WRITE);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state    <= RAM_IDLE;
         wait_cnt <= '0;
      end else begin
         case (state)
            RAM_IDLE: begin
               if (stb_i) begin
                  wait_cnt <= '0;
                  if (RAM_WAIT == 0) begin
                     state <= RAM_ACK;
                  end else begin
                     state <= periph_pkg::RAM_WAIT;
                  end
               end
            end
            periph_pkg::RAM_WAIT: begin
               if (wait_cnt == LAST_CNT) begin
                  state <= RAM_ACK;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            RAM_ACK: state <= RAM_IDLE; // One ack cycle per strobe.
            default: state <= RAM_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (sel_i[b]) begin
               mem[word_idx][8*b +: 8] <= data_i[8*b +: 8];
            end
         end
      end
      data_o <= mem[word_idx]; // Address is stable well before ack.
   end

endmodule

/* design/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs
   import iob_wb_pkg::*;
   import periph_pkg::*;
#(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                stb_i,
   input  logic                we_i,
   input  logic [  ADDR_W-1:0] addr_i,
   input  logic [DATA_W/8-1:0] sel_i,
   input  logic [  DATA_W-1:0] data_i,
   output logic                ack_o,
   output logic [  DATA_W-1:0] data_o
);

   reg_map_e          reg_idx;
   wb_op_e            op;
   logic              access;
   logic              wr_en;
   logic [DATA_W-1:0] scratch;
   logic [DATA_W-1:0] wcount;

   assign reg_idx = reg_map_e'(addr_i[3:2]);
   assign op      = wb_op_e'(we_i);
   assign access  = stb_i & ~ack_o; // First strobe cycle only.
   assign wr_en   = access & (op == WB_WRITE);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_o   <= 1'b0;
         scratch <= '0;
         wcount  <= '0;
      end else begin
         ack_o <= access;
         if (wr_en) begin
            wcount <= wcount + 1'b1; // Any write to this block counts.
         end
         if (wr_en && reg_idx == REG_SCRATCH) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
               if (sel_i[b]) begin
                  scratch[8*b +: 8] <= data_i[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (access) begin
         case (reg_idx)
            REG_ID:      data_o <= DATA_W'(PERIPH_ID);
            REG_SCRATCH: data_o <= scratch;
            REG_WCOUNT:  data_o <= wcount;
            default:     data_o <= '0; // Unmapped word reads zero.
         endcase
      end
   end

endmodule

/* design/iob_wb_subsys.sv */
`timescale 1ns/1ps

module iob_wb_subsys #(
   parameter int ADDR_W     = 32,
   parameter int DATA_W     = 32,
   parameter int READ_BYTES = 4,
   parameter int RAM_ADDR_W = 8,
   parameter int RAM_WAIT   = 2
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                iob_avalid_i,
   input  logic [  ADDR_W-1:0] iob_addr_i,
   input  logic [  DATA_W-1:0] iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_ready_o,
   output logic                iob_rvalid_o,
   output logic [  DATA_W-1:0] iob_rdata_o
);

   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [  ADDR_W-1:0] wb_addr;
   logic [DATA_W/8-1:0] wb_select;
   logic [  DATA_W-1:0] wb_wdata;
   logic                wb_ack;
   logic [  DATA_W-1:0] wb_rdata;
   logic                ram_stb;
   logic                ram_ack;
   logic [  DATA_W-1:0] ram_rdata;
   logic                regs_stb;
   logic                regs_ack;
   logic [  DATA_W-1:0] regs_rdata;

   iob_iob2wishbone #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .READ_BYTES(READ_BYTES)
   ) u_bridge (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .iob_avalid_i(iob_avalid_i),
      .iob_addr_i  (iob_addr_i),
      .iob_wdata_i (iob_wdata_i),
      .iob_wstrb_i (iob_wstrb_i),
      .iob_rvalid_o(iob_rvalid_o),
      .iob_rdata_o (iob_rdata_o),
      .iob_ready_o (iob_ready_o),
      .wb_addr_o   (wb_addr),
      .wb_select_o (wb_select),
      .wb_we_o     (wb_we),
      .wb_cyc_o    (wb_cyc),
      .wb_stb_o    (wb_stb),
      .wb_data_o   (wb_wdata),
      .wb_ack_i    (wb_ack),
      .wb_data_i   (wb_rdata)
   );

   wb_decoder #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_decoder (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wb_cyc_i   (wb_cyc),
      .wb_stb_i   (wb_stb),
      .wb_addr_i  (wb_addr),
      .ram_ack_i  (ram_ack),
      .ram_data_i (ram_rdata),
      .regs_ack_i (regs_ack),
      .regs_data_i(regs_rdata),
      .ram_stb_o  (ram_stb),
      .regs_stb_o (regs_stb),
      .wb_ack_o   (wb_ack),
      .wb_data_o  (wb_rdata)
   );

   wb_ram #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .RAM_ADDR_W(RAM_ADDR_W),
      .RAM_WAIT  (RAM_WAIT)
   ) u_ram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .stb_i  (ram_stb),
      .we_i   (wb_we),
      .addr_i (wb_addr),
      .sel_i  (wb_select),
      .data_i (wb_wdata),
      .ack_o  (ram_ack),
      .data_o (ram_rdata)
   );

   wb_regs #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) u_regs (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .stb_i  (regs_stb),
      .we_i   (wb_we),
      .addr_i (wb_addr),
      .sel_i  (wb_select),
      .data_i (wb_wdata),
      .ack_o  (regs_ack),
      .data_o (regs_rdata)
   );

endmodule

/* verif/iob_wb_chk.sv */
`timescale 1ns/1ps

module iob_wb_chk #(
   parameter int ADDR_W = 32,
   parameter int DATA_W = 32
) (
   input logic                clk_i,
   input logic                rst_n_i,
   input logic                avalid_i,
   input logic [DATA_W/8-1:0] wstrb_i,
   input logic                ready_i,
   input logic                rvalid_i,
   input logic                stb_i,
   input logic                ack_i,
   input logic                we_i,
   input logic [  ADDR_W-1:0] addr_i,
   input logic [  DATA_W-1:0] data_i,
   input logic [DATA_W/8-1:0] sel_i
);

   logic accept;
   logic read_pending; // A read was accepted and has not returned yet.

   assign accept = avalid_i & ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         read_pending <= 1'b0;
      end else begin
         if (rvalid_i) begin
            read_pending <= 1'b0;
         end
         if (accept && wstrb_i == '0) begin
            read_pending <= 1'b1; // Back-to-back read wins.
         end
      end
   end

   a_stb_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      stb_i && !ack_i |=> stb_i && $stable(addr_i) && $stable(data_i)
                          && $stable(sel_i) && $stable(we_i))
      else $error("wishbone strobe dropped or cycle changed before ack");

   a_rvalid_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i |-> read_pending)
      else $error("rvalid without an outstanding read");

   a_rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      rvalid_i |=> !rvalid_i)
      else $error("rvalid held for more than one cycle");

   a_reset_idle: assert property (@(posedge clk_i)
      !rst_n_i |=> !stb_i && ready_i && !rvalid_i)
      else $error("bridge not idle after reset");

endmodule

bind iob_iob2wishbone iob_wb_chk #(
   .ADDR_W(ADDR_W),
   .DATA_W(DATA_W)
) u_chk (
   .clk_i   (clk_i),
   .rst_n_i (rst_n_i),
   .avalid_i(iob_avalid_i),
   .wstrb_i (iob_wstrb_i),
   .ready_i (iob_ready_o),
   .rvalid_i(iob_rvalid_o),
   .stb_i   (wb_stb_o),
   .ack_i   (wb_ack_i),
   .we_i    (wb_we_o),
   .addr_i  (wb_addr_o),
   .data_i  (wb_data_o),
   .sel_i   (wb_select_o)
);

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0) clk_o = ~clk_o; // Half period per toggle.
      end
   end

endmodule

/* verif/iob_wb_tb.sv */
`timescale 1ns/1ps

module iob_wb_tb
   import iob_wb_pkg::*;
   import periph_pkg::*;
();

   localparam int ADDR_W     = 32;
   localparam int DATA_W     = 32;
   localparam int READ_BYTES = 4;
   localparam int RAM_ADDR_W = 8;
   localparam int RAM_WAIT   = 2;
   localparam int REG_LAT    = 3;
   localparam int RAM_LAT    = RAM_WAIT + 3;
   localparam int TIMEOUT    = 40;
   localparam logic [ADDR_W-1:0] REG_BASE = 32'h1 << REGS_BASE_BIT;

   logic                clk;
   logic                rst_n;
   logic                iob_avalid;
   logic [  ADDR_W-1:0] iob_addr;
   logic [  DATA_W-1:0] iob_wdata;
   logic [DATA_W/8-1:0] iob_wstrb;
   logic                iob_ready;
   logic                iob_rvalid;
   logic [  DATA_W-1:0] iob_rdata;

   logic [DATA_W-1:0] ram_model [2**RAM_ADDR_W];
   logic [ADDR_W-1:0] written [$];
   logic [DATA_W-1:0] scratch_model;
   int                reg_writes;

   tb_clk_gen #(.PERIOD_NS(4.0)) u_clk (.clk_o(clk));

   iob_wb_subsys #(
      .ADDR_W    (ADDR_W),
      .DATA_W    (DATA_W),
      .READ_BYTES(READ_BYTES),
      .RAM_ADDR_W(RAM_ADDR_W),
      .RAM_WAIT  (RAM_WAIT)
   ) UUT (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .iob_avalid_i(iob_avalid),
      .iob_addr_i  (iob_addr),
      .iob_wdata_i (iob_wdata),
      .iob_wstrb_i (iob_wstrb),
      .iob_ready_o (iob_ready),
      .iob_rvalid_o(iob_rvalid),
      .iob_rdata_o (iob_rdata)
   );

   task automatic value_error(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic event_error(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [DATA_W/8-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input reg_map_e r);
      return REG_BASE | (32'(r) << 2);
   endfunction

   // One request, checked for latency and back-pressure.
   task automatic iob_access(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [DATA_W/8-1:0] s, input int exp_lat,
                             output logic [DATA_W-1:0] rd);
      int cycles;
      cycles = 0;
      while (!iob_ready) begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) event_error("timeout while waiting for ready before a request");
      end
      iob_avalid = 1'b1;
      iob_addr   = a;
      iob_wdata  = d;
      iob_wstrb  = s;
      @(negedge clk);
      iob_avalid = 1'b0;
      iob_addr   = $urandom(); // Bridge must work from its captured copy.
      iob_wdata  = $urandom();
      iob_wstrb  = 4'($urandom());
      cycles = 1;
      while (!((s == '0) ? iob_rvalid : iob_ready)) begin
         assert (!iob_ready) else event_error("ready high while a request is outstanding");
         assert (!iob_rvalid) else event_error("rvalid before the request completed");
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT) event_error("timeout while waiting for the request to complete");
      end
      assert (cycles == exp_lat) else value_error("latency", 32'(cycles), 32'(exp_lat));
      assert (iob_ready) else value_error("iob_ready_o", 32'(iob_ready), 32'h1);
      if (s != '0) begin
         assert (!iob_rvalid) else event_error("a write produced rvalid");
      end
      rd = iob_rdata;
   endtask

   task automatic iob_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [DATA_W/8-1:0] s, input int exp_lat);
      logic [DATA_W-1:0] ignored;
      iob_access(a, d, s, exp_lat, ignored);
   endtask

   task automatic iob_read(input logic [ADDR_W-1:0] a, input int exp_lat,
                           output logic [DATA_W-1:0] rd);
      iob_access(a, '0, '0, exp_lat, rd);
   endtask

   task automatic ram_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                            input logic [DATA_W/8-1:0] s);
      iob_write(a, d, s, RAM_LAT);
      ram_model[a[RAM_ADDR_W+1:2]] = merge_bytes(ram_model[a[RAM_ADDR_W+1:2]], d, s);
   endtask

   task automatic ram_check(input logic [ADDR_W-1:0] a);
      logic [DATA_W-1:0] rd;
      iob_read(a, RAM_LAT, rd);
      assert (rd == ram_model[a[RAM_ADDR_W+1:2]])
         else value_error("iob_rdata_o", rd, ram_model[a[RAM_ADDR_W+1:2]]);
   endtask

   task automatic reg_write(input reg_map_e r, input logic [DATA_W-1:0] d,
                            input logic [DATA_W/8-1:0] s);
      iob_write(reg_addr(r), d, s, REG_LAT);
      reg_writes++; // Every write to the block counts.
      if (r == REG_SCRATCH) begin
         scratch_model = merge_bytes(scratch_model, d, s);
      end
   endtask

   task automatic reg_check(input reg_map_e r, input logic [DATA_W-1:0] exp);
      logic [DATA_W-1:0] rd;
      iob_read(reg_addr(r), REG_LAT, rd);
      assert (rd == exp) else value_error("iob_rdata_o", rd, exp);
   endtask

   initial begin
      logic [ADDR_W-1:0] a;
      void'($urandom(32'hab18_a75f));
      rst_n         = 1'b0;
      iob_avalid    = 1'b0;
      iob_addr      = '0;
      iob_wdata     = '0;
      iob_wstrb     = '0;
      scratch_model = '0;
      reg_writes    = 0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (iob_ready && !iob_rvalid) else event_error("bridge not idle after reset");

      for (int i = 0; i < 24; i++) begin
         a = $urandom() & ~REG_BASE & ~32'h3; // Upper bits vary, still RAM.
         ram_write(a, $urandom(), 4'hf);
         written.push_back(a);
      end
      foreach (written[i]) ram_check(written[i]);

      for (int i = 0; i < 24; i++) begin
         a = written[$urandom_range(written.size() - 1)];
         ram_write(a, $urandom(), 4'($urandom_range(14, 1)));
         ram_check(a);
      end

      reg_check(REG_ID, PERIPH_ID);
      reg_write(REG_ID, $urandom(), 4'hf);
      reg_check(REG_ID, PERIPH_ID);
      reg_check(REG_SCRATCH, scratch_model);
      reg_write(REG_SCRATCH, $urandom(), 4'hf);
      reg_check(REG_SCRATCH, scratch_model);
      for (int i = 0; i < 6; i++) begin
         reg_write(REG_SCRATCH, $urandom(), 4'($urandom_range(14, 1)));
         reg_check(REG_SCRATCH, scratch_model);
      end

      reg_check(REG_WCOUNT, 32'(reg_writes));
      for (int i = 0; i < 4; i++) begin
         ram_write(written[i], $urandom(), 4'hf);
      end
      reg_check(REG_WCOUNT, 32'(reg_writes)); // RAM writes leave it alone.
      reg_write(REG_WCOUNT, $urandom(), 4'hf);
      reg_check(REG_WCOUNT, 32'(reg_writes));
      foreach (written[i]) ram_check(written[i]);

      $display("All tests passed!");
      $finish;
   end

endmodule

/* list.f */
design/iob_wb_pkg.sv
design/periph_pkg.sv
design/iob_iob2wishbone.sv
design/wb_decoder.sv
design/wb_ram.sv
design/wb_regs.sv
design/iob_wb_subsys.sv
verif/iob_wb_chk.sv
verif/tb_clk_gen.sv
verif/iob_wb_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module iob_wb_tb \
   -f list.f -Mdir obj_dir -o iob_wb_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/iob_wb_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
